// File: common/pms_settings.svh
// PMS settings
// Address window of the SoC control registers as the PS side sees it,
// register offsets, reset values and the timing thresholds in
// s_soc_clk cycles (scaled down for simulation)

`ifndef PMS_SETTINGS_SVH
`define PMS_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// address map
//////////////////////////////////////////////////////////////////////

`define PMS_PL_SOC_CTRL_BASE 32'h1A10_4000  // soc ctrl in the pl view
`define PMS_PL2PS_OFS        32'h8600_0000  // split window shift, pl to ps
`define PMS_EXT_BASE         (`PMS_PL_SOC_CTRL_BASE + `PMS_PL2PS_OFS)

// 32-bit registers, bit 2 set means upper half of the 64-bit word
`define PMS_OFS_BOOT_ADDR    12'h004
`define PMS_OFS_FETCH_EN     12'h008
`define PMS_OFS_CORE_STATUS  12'h0A0
`define PMS_OFS_BOOTSEL      12'h0C4

`define PMS_BOOT_ADDR_RST    32'h1C00_0880  // default entry point

//////////////////////////////////////////////////////////////////////
// timing, in clock cycles
//////////////////////////////////////////////////////////////////////

`define PMS_BTN_MIN_CYC      4   // shorter runs are glitches
`define PMS_BTN_LONG_CYC     64  // forced power-down from here on
`define PMS_SEQ_STEP_CYC     8   // dwell in S4 and in S3
`define PMS_RST_REL_CYC      16  // power-good to core reset release

`endif

// File: common/pms_pkg.sv
// PMS package
// Enumerated types shared by the register block, the ACPI sequencer
// and the core release logic

package pms_pkg;

  // ACPI sleep states, S5 is soft-off
  typedef enum logic [1:0] {
    ACPI_S5 = 2'd0,
    ACPI_S4 = 2'd1,
    ACPI_S3 = 2'd2,
    ACPI_S0 = 2'd3
  } acpi_state_e;

  // register hit by the decoded bus address
  typedef enum logic [2:0] {
    SEL_NONE        = 3'd0,
    SEL_BOOT_ADDR   = 3'd1,
    SEL_FETCH_EN    = 3'd2,
    SEL_CORE_STATUS = 3'd3,
    SEL_BOOTSEL     = 3'd4
  } reg_sel_e;

  // core reset release FSM
  typedef enum logic [1:0] {
    REL_HELD = 2'd0,  // core in reset
    REL_WAIT = 2'd1,  // power good, settling
    REL_RUN  = 2'd2   // reset released
  } release_state_e;

endpackage

// File: hw/soc_ctrl/soc_ctrl_regs.sv
// SoC control registers
// Single-beat 64-bit register bus into the external SoC control window.
// Decodes the 40-bit PS address, applies per-half write strobes and
// answers every request exactly one cycle later. Holds boot select,
// boot address, fetch enable and core status.

`timescale 1ns/1ns

`include "pms_settings.svh"

module soc_ctrl_regs import pms_pkg::*; (
  input  logic        s_soc_clk,
  input  logic        rst_n_i,
  input  logic        wr_en_i,
  input  logic        rd_en_i,
  input  logic [39:0] addr_i,
  input  logic [63:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  output logic [63:0] rdata_o,
  output logic        resp_valid_o,
  output logic        resp_err_o,
  output logic        fetch_en_o,
  output logic [31:0] boot_addr_o
);

  logic [31:0] win_ofs;      // byte offset into the window
  logic        in_win;
  reg_sel_e    reg_sel;
  logic        req_err;
  logic        hi_half;      // register sits in bits 63:32
  logic        half_strb_ok;
  logic [31:0] wr_word;
  logic [31:0] rd_word;
  logic        wr_ok;

  logic [31:0] bootsel_q;
  logic [31:0] boot_addr_q;
  logic [31:0] fetch_en_q;
  logic [31:0] core_status_q;  // bit 31 eoc, 30:0 exit code

  logic        resp_valid_q;
  logic        resp_err_q;
  logic [63:0] rdata_q;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // wraps to a large value below the base, so one compare covers both ends
    win_ofs = addr_i[31:0] - `PMS_EXT_BASE;
    in_win  = (addr_i[39:32] == 8'h00) && (win_ofs[31:12] == 20'h0_0000);  // 4 KiB

    reg_sel = SEL_NONE;
    if (in_win) begin
      case (win_ofs[11:0])
        `PMS_OFS_BOOT_ADDR:   reg_sel = SEL_BOOT_ADDR;
        `PMS_OFS_FETCH_EN:    reg_sel = SEL_FETCH_EN;
        `PMS_OFS_CORE_STATUS: reg_sel = SEL_CORE_STATUS;
        `PMS_OFS_BOOTSEL:     reg_sel = SEL_BOOTSEL;
        default:              reg_sel = SEL_NONE;
      endcase
    end
  end

  assign req_err = (reg_sel == SEL_NONE);

  // offsets match exactly, so bit 2 of the address picks the half
  assign hi_half      = win_ofs[2];
  assign half_strb_ok = hi_half ? (&wstrb_i[7:4]) : (&wstrb_i[3:0]);
  assign wr_word      = hi_half ? wdata_i[63:32] : wdata_i[31:0];
  assign wr_ok        = wr_en_i && !req_err && half_strb_ok;

  always_comb begin
    case (reg_sel)
      SEL_BOOT_ADDR:   rd_word = boot_addr_q;
      SEL_FETCH_EN:    rd_word = fetch_en_q;
      SEL_CORE_STATUS: rd_word = core_status_q;
      SEL_BOOTSEL:     rd_word = bootsel_q;
      default:         rd_word = 32'h0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge s_soc_clk) begin
    if (!rst_n_i) begin
      bootsel_q     <= 32'h0;
      boot_addr_q   <= `PMS_BOOT_ADDR_RST;
      fetch_en_q    <= 32'h0;
      core_status_q <= 32'h0;
    end else if (wr_ok) begin
      case (reg_sel)
        SEL_BOOT_ADDR:   boot_addr_q   <= wr_word;
        SEL_FETCH_EN:    fetch_en_q    <= wr_word;
        SEL_CORE_STATUS: core_status_q <= wr_word;
        SEL_BOOTSEL:     bootsel_q     <= wr_word;
        default:         ;
      endcase
    end
  end

  // response one cycle after the request, no back-pressure
  always_ff @(posedge s_soc_clk) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
      resp_err_q   <= 1'b0;
    end else begin
      resp_valid_q <= wr_en_i || rd_en_i;
      resp_err_q   <= (wr_en_i || rd_en_i) && req_err;
    end
  end

  // read data in its own half, zero elsewhere and on errors
  always_ff @(posedge s_soc_clk) begin
    if (rd_en_i && !req_err) begin
      rdata_q <= hi_half ? {rd_word, 32'h0} : {32'h0, rd_word};
    end else begin
      rdata_q <= 64'h0;
    end
  end

  assign rdata_o      = rdata_q;
  assign resp_valid_o = resp_valid_q;
  assign resp_err_o   = resp_err_q;
  assign fetch_en_o   = fetch_en_q[0];
  assign boot_addr_o  = boot_addr_q;

  // a response is never produced without a request the cycle before
  a_resp_after_req : assert property (@(posedge s_soc_clk) disable iff (!rst_n_i)
    resp_valid_o |-> $past(wr_en_i || rd_en_i))
    else $error("resp_valid_o without a request in the previous cycle");

endmodule

// File: hw/acpi/acpi_pwr_seq.sv
// ACPI power sequencer
// Synchronises the power button, measures the press length and
// classifies it on release. A short press in S5 walks S4, S3 and S0;
// a long press outside S5 drops straight back to S5.

`timescale 1ns/1ns

`include "pms_settings.svh"

module acpi_pwr_seq import pms_pkg::*; (
  input  logic s_soc_clk,
  input  logic rst_n_i,
  input  logic pwr_btn_n_i,
  output logic slp_s3_n_o,
  output logic slp_s4_n_o,
  output logic slp_s5_n_o,
  output logic pwrgd_o
);

  logic [1:0]  btn_sync_q;
  logic        btn_n;        // synchronised, active low
  logic [6:0]  press_cnt_q;  // saturates at the long threshold
  logic        release_evt;
  logic        short_press;
  logic        long_press;

  acpi_state_e state_q;
  acpi_state_e state_d;
  logic [3:0]  step_cnt_q;
  logic        step_done;

  //////////////////////////////////////////////////////////////////////
  // button input
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge s_soc_clk) begin
    if (!rst_n_i) begin
      btn_sync_q <= 2'b11;  // released
    end else begin
      btn_sync_q <= {btn_sync_q[0], pwr_btn_n_i};
    end
  end

  assign btn_n = btn_sync_q[1];

  // length of the current low run
  always_ff @(posedge s_soc_clk) begin
    if (!rst_n_i) begin
      press_cnt_q <= 7'd0;
    end else if (btn_n) begin
      press_cnt_q <= 7'd0;
    end else if (press_cnt_q != 7'(`PMS_BTN_LONG_CYC)) begin
      press_cnt_q <= press_cnt_q + 7'd1;
    end
  end

  // judged on the first high after a low run
  assign release_evt = btn_n && (press_cnt_q != 7'd0);
  assign long_press  = release_evt && (press_cnt_q == 7'(`PMS_BTN_LONG_CYC));
  assign short_press = release_evt && !long_press
                       && (press_cnt_q >= 7'(`PMS_BTN_MIN_CYC));

  //////////////////////////////////////////////////////////////////////
  // sequencer FSM
  //////////////////////////////////////////////////////////////////////

  assign step_done = (step_cnt_q == 4'(`PMS_SEQ_STEP_CYC - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      ACPI_S5: begin
        if (short_press) state_d = ACPI_S4;  // long press ignored here
      end
      ACPI_S4: begin
        if (long_press) begin
          state_d = ACPI_S5;
        end else if (step_done) begin
          state_d = ACPI_S3;
        end
      end
      ACPI_S3: begin
        if (long_press) begin
          state_d = ACPI_S5;
        end else if (step_done) begin
          state_d = ACPI_S0;
        end
      end
      ACPI_S0: begin
        if (long_press) state_d = ACPI_S5;  // forced power-down
      end
      default: state_d = ACPI_S5;
    endcase
  end

  always_ff @(posedge s_soc_clk) begin
    if (!rst_n_i) begin
      state_q <= ACPI_S5;
    end else begin
      state_q <= state_d;
    end
  end

  // dwell counter runs only in the intermediate states
  always_ff @(posedge s_soc_clk) begin
    if (!rst_n_i) begin
      step_cnt_q <= 4'd0;
    end else if (state_d != state_q) begin
      step_cnt_q <= 4'd0;
    end else if ((state_q == ACPI_S4) || (state_q == ACPI_S3)) begin
      step_cnt_q <= step_cnt_q + 4'd1;
    end
  end

  // sleep lines deassert one by one on the way up
  assign slp_s5_n_o = (state_q != ACPI_S5);
  assign slp_s4_n_o = (state_q == ACPI_S3) || (state_q == ACPI_S0);
  assign slp_s3_n_o = (state_q == ACPI_S0);
  assign pwrgd_o    = (state_q == ACPI_S0);

  a_slp_order : assert property (@(posedge s_soc_clk) disable iff (!rst_n_i)
    (slp_s3_n_o |-> slp_s4_n_o) and (slp_s4_n_o |-> slp_s5_n_o))
    else $error("sleep outputs out of order");

endmodule

// File: hw/core_release.sv
// Core release
// Holds the core in reset until power good has been stable for the
// settling delay, latches the entry point and then passes the fetch
// enable register through to the core

`timescale 1ns/1ns

`include "pms_settings.svh"

module core_release import pms_pkg::*; (
  input  logic        s_soc_clk,
  input  logic        rst_n_i,
  input  logic        pwrgd_i,
  input  logic        fetch_en_i,
  input  logic [31:0] boot_addr_i,
  output logic        cpu_reset_n_o,
  output logic        core_fetch_en_o,
  output logic [31:0] core_boot_addr_o
);

  release_state_e state_q;
  logic [4:0]     settle_cnt_q;
  logic           settle_done;
  logic           fetch_q;
  logic [31:0]    boot_addr_q;

  assign settle_done = (settle_cnt_q == 5'(`PMS_RST_REL_CYC - 1));

  always_ff @(posedge s_soc_clk) begin
    if (!rst_n_i) begin
      state_q      <= REL_HELD;
      settle_cnt_q <= 5'd0;
    end else begin
      case (state_q)
        REL_HELD: begin
          if (pwrgd_i) begin
            state_q      <= REL_WAIT;
            settle_cnt_q <= 5'd1;  // first cycle of power good already seen
          end
        end
        REL_WAIT: begin
          if (!pwrgd_i) begin
            state_q <= REL_HELD;
          end else if (settle_done) begin
            state_q <= REL_RUN;
          end else begin
            settle_cnt_q <= settle_cnt_q + 5'd1;
          end
        end
        REL_RUN: begin
          if (!pwrgd_i) state_q <= REL_HELD;
        end
        default: state_q <= REL_HELD;
      endcase
    end
  end

  // entry point taken as the reset goes away
  always_ff @(posedge s_soc_clk) begin
    if ((state_q == REL_WAIT) && pwrgd_i && settle_done) begin
      boot_addr_q <= boot_addr_i;
    end
  end

  // fetch follows the register one cycle later, only while running
  always_ff @(posedge s_soc_clk) begin
    if (!rst_n_i) begin
      fetch_q <= 1'b0;
    end else begin
      fetch_q <= (state_q == REL_RUN) && pwrgd_i && fetch_en_i;
    end
  end

  assign cpu_reset_n_o    = (state_q == REL_RUN);
  assign core_fetch_en_o  = fetch_q;
  assign core_boot_addr_o = boot_addr_q;

  a_fetch_needs_reset_off : assert property (@(posedge s_soc_clk) disable iff (!rst_n_i)
    core_fetch_en_o |-> cpu_reset_n_o)
    else $error("core fetch enabled while the core is in reset");

endmodule

// File: hw/pms_top.sv
// PMS top
// Register bus to the SoC control registers, power button to the ACPI
// sequencer, and the core reset and fetch control built from both

`timescale 1ns/1ns

module pms_top (
  input  logic        s_soc_clk,
  input  logic        rst_n_i,
  // register bus
  input  logic        wr_en_i,
  input  logic        rd_en_i,
  input  logic [39:0] addr_i,
  input  logic [63:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  output logic [63:0] rdata_o,
  output logic        resp_valid_o,
  output logic        resp_err_o,
  // power button and ACPI lines
  input  logic        pwr_btn_n_i,
  output logic        slp_s3_n_o,
  output logic        slp_s4_n_o,
  output logic        slp_s5_n_o,
  output logic        pwrgd_o,
  // core control
  output logic        cpu_reset_n_o,
  output logic        core_fetch_en_o,
  output logic [31:0] core_boot_addr_o
);

  logic        fetch_en;
  logic [31:0] boot_addr;
  logic        pwrgd;

  soc_ctrl_regs i_soc_ctrl_regs (
    .s_soc_clk   (s_soc_clk),
    .rst_n_i     (rst_n_i),
    .wr_en_i     (wr_en_i),
    .rd_en_i     (rd_en_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .rdata_o     (rdata_o),
    .resp_valid_o(resp_valid_o),
    .resp_err_o  (resp_err_o),
    .fetch_en_o  (fetch_en),
    .boot_addr_o (boot_addr)
  );

  acpi_pwr_seq i_acpi_pwr_seq (
    .s_soc_clk  (s_soc_clk),
    .rst_n_i    (rst_n_i),
    .pwr_btn_n_i(pwr_btn_n_i),
    .slp_s3_n_o (slp_s3_n_o),
    .slp_s4_n_o (slp_s4_n_o),
    .slp_s5_n_o (slp_s5_n_o),
    .pwrgd_o    (pwrgd)
  );

  assign pwrgd_o = pwrgd;  // also feeds the release logic

  core_release i_core_release (
    .s_soc_clk       (s_soc_clk),
    .rst_n_i         (rst_n_i),
    .pwrgd_i         (pwrgd),
    .fetch_en_i      (fetch_en),
    .boot_addr_i     (boot_addr),
    .cpu_reset_n_o   (cpu_reset_n_o),
    .core_fetch_en_o (core_fetch_en_o),
    .core_boot_addr_o(core_boot_addr_o)
  );

endmodule

// File: test/tb_pms_tasks.svh
// PMS testbench helpers
// Register model of the SoC control window, bus access with response
// checks, power button drive and output watch tasks

`ifndef TB_PMS_TASKS_SVH
`define TB_PMS_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// register model
//////////////////////////////////////////////////////////////////////

// 0 boot address, 1 fetch enable, 2 core status, 3 boot select
function automatic logic [11:0] reg_offset(input logic [1:0] idx);
  case (idx)
    2'd0:    reg_offset = `PMS_OFS_BOOT_ADDR;
    2'd1:    reg_offset = `PMS_OFS_FETCH_EN;
    2'd2:    reg_offset = `PMS_OFS_CORE_STATUS;
    default: reg_offset = `PMS_OFS_BOOTSEL;
  endcase
endfunction

function automatic logic [39:0] reg_address(input logic [1:0] idx);
  reg_address = {8'h00, `PMS_EXT_BASE + {20'h0, reg_offset(idx)}};
endfunction

// -1 for anything that must answer with an error
function automatic int reg_index(input logic [39:0] addr);
  logic [31:0] lo;
  int          idx;
  lo  = addr[31:0];
  idx = -1;
  if ((addr[39:32] == 8'h00) && (lo >= `PMS_EXT_BASE)
      && (lo < `PMS_EXT_BASE + 32'h1000)) begin
    case (lo[11:0])  // window base is 4 KiB aligned
      `PMS_OFS_BOOT_ADDR:   idx = 0;
      `PMS_OFS_FETCH_EN:    idx = 1;
      `PMS_OFS_CORE_STATUS: idx = 2;
      `PMS_OFS_BOOTSEL:     idx = 3;
      default:              idx = -1;
    endcase
  end
  reg_index = idx;
endfunction

task automatic model_reset();
  model_regs[0] = `PMS_BOOT_ADDR_RST;
  model_regs[1] = 32'h0;
  model_regs[2] = 32'h0;
  model_regs[3] = 32'h0;
endtask

task automatic model_write(input logic [39:0] addr, input logic [63:0] data,
                           input logic [7:0] strb);
  int idx;
  idx = reg_index(addr);
  if (idx >= 0) begin
    if (addr[2] && (&strb[7:4])) begin
      model_regs[idx] = data[63:32];
    end else if (!addr[2] && (&strb[3:0])) begin
      model_regs[idx] = data[31:0];
    end
  end
endtask

function automatic logic [63:0] expected_rdata(input logic [39:0] addr);
  int idx;
  idx = reg_index(addr);
  if (idx < 0) begin
    expected_rdata = 64'h0;
  end else if (addr[2]) begin
    expected_rdata = {model_regs[idx], 32'h0};
  end else begin
    expected_rdata = {32'h0, model_regs[idx]};
  end
endfunction

//////////////////////////////////////////////////////////////////////
// error reporting
//////////////////////////////////////////////////////////////////////

task automatic report_error(input string msg);
  $display("error at %0t ns: %s", $time, msg);
  err_count++;
endtask

task automatic report_timeout(input string what, input int cyc);
  $display("timeout: %s not seen within %0d clock cycles", what, cyc);
  err_count++;
endtask

//////////////////////////////////////////////////////////////////////
// register bus
//////////////////////////////////////////////////////////////////////

// starts and ends 1 ns after a rising edge
task automatic bus_access(input logic is_wr, input logic [39:0] addr,
                          input logic [63:0] data, input logic [7:0] strb);
  int          waited;
  logic        exp_err;
  logic [63:0] exp_rdata;
  exp_err   = (reg_index(addr) < 0);
  exp_rdata = expected_rdata(addr);
  wr_en_i   = is_wr;
  rd_en_i   = !is_wr;
  addr_i    = addr;
  wdata_i   = data;
  wstrb_i   = strb;
  waited    = 0;
  do begin
    @(posedge s_soc_clk);
    #DRIVE_DLY;
    wr_en_i = 1'b0;  // single beat
    rd_en_i = 1'b0;
    waited++;
  end while ((resp_valid_o !== 1'b1) && (waited < BUS_TIMEOUT_CYC));
  if (resp_valid_o !== 1'b1) begin
    report_timeout($sformatf("bus response for address %h", addr), BUS_TIMEOUT_CYC);
  end else begin
    if (waited != 1) begin
      report_error($sformatf("response for %h after %0d cycles, expected 1", addr, waited));
    end
    if (resp_err_o !== exp_err) begin
      report_error($sformatf("resp_err_o %b for %h, expected %b", resp_err_o, addr, exp_err));
    end
    if (!is_wr && (rdata_o !== exp_rdata)) begin
      report_error($sformatf("read of %h returned %h, expected %h", addr, rdata_o,
                             exp_rdata));
    end
  end
  if (is_wr) begin
    model_write(addr, data, strb);
  end
endtask

task automatic idle_cycles(input int n);
  for (int i = 0; i < n; i++) begin
    @(posedge s_soc_clk);
    #DRIVE_DLY;
    if (resp_valid_o !== 1'b0) begin
      report_error("resp_valid_o high without a request");
    end
  end
endtask

//////////////////////////////////////////////////////////////////////
// power button and outputs
//////////////////////////////////////////////////////////////////////

// pin held low for exactly n cycles
task automatic press_button(input int n);
  pwr_btn_n_i = 1'b0;
  repeat (n) begin
    @(posedge s_soc_clk);
    #DRIVE_DLY;
  end
  pwr_btn_n_i = 1'b1;
endtask

function automatic logic probe(input int which);
  case (which)
    0:       probe = slp_s5_n_o;
    1:       probe = slp_s4_n_o;
    2:       probe = slp_s3_n_o;
    3:       probe = pwrgd_o;
    4:       probe = cpu_reset_n_o;
    default: probe = core_fetch_en_o;
  endcase
endfunction

function automatic string signal_name(input int which);
  case (which)
    0:       signal_name = "slp_s5_n_o";
    1:       signal_name = "slp_s4_n_o";
    2:       signal_name = "slp_s3_n_o";
    3:       signal_name = "pwrgd_o";
    4:       signal_name = "cpu_reset_n_o";
    default: signal_name = "core_fetch_en_o";
  endcase
endfunction

// waited counts the rising edges until the level shows up
task automatic wait_level(input int which, input logic level, input int max_cyc,
                          output int waited, output logic ok);
  waited = 0;
  while ((probe(which) !== level) && (waited < max_cyc)) begin
    @(posedge s_soc_clk);
    #DRIVE_DLY;
    waited++;
  end
  ok = (probe(which) === level);
  if (!ok) begin
    report_timeout($sformatf("%s at %b", signal_name(which), level), max_cyc);
  end
endtask

function automatic logic [37:0] output_snapshot();
  output_snapshot = {slp_s5_n_o, slp_s4_n_o, slp_s3_n_o, pwrgd_o,
                     cpu_reset_n_o, core_fetch_en_o, core_boot_addr_o};
endfunction

task automatic watch_outputs(input logic [37:0] snap, input int n);
  for (int i = 0; i < n; i++) begin
    @(posedge s_soc_clk);
    #DRIVE_DLY;
    if (output_snapshot() !== snap) begin
      report_error($sformatf("outputs changed to %h, expected %h", output_snapshot(), snap));
    end
  end
endtask

`endif

// File: test/tb_pms_top.sv
// PMS testbench
// Drives the register bus and the power button of the PMS top with
// random stimulus and checks reads, power sequencing and core release
// against a register model and the sequencing rules

`timescale 1ns/1ns

`include "pms_settings.svh"

module tb_pms_top;

  localparam int CLK_HALF_NS     = 4;   // 8 ns period
  localparam int RST_CYC         = 16;
  localparam int DRIVE_DLY       = 1;
  localparam int BUS_TIMEOUT_CYC = 4;
  localparam int SYNC_STAGES     = 2;   // button synchroniser depth
  localparam int RAND_OPS        = 200;

  logic        s_soc_clk;
  logic        rst_n_i;
  logic        wr_en_i;
  logic        rd_en_i;
  logic [39:0] addr_i;
  logic [63:0] wdata_i;
  logic [7:0]  wstrb_i;
  logic [63:0] rdata_o;
  logic        resp_valid_o;
  logic        resp_err_o;
  logic        pwr_btn_n_i;
  logic        slp_s3_n_o;
  logic        slp_s4_n_o;
  logic        slp_s5_n_o;
  logic        pwrgd_o;
  logic        cpu_reset_n_o;
  logic        core_fetch_en_o;
  logic [31:0] core_boot_addr_o;

  logic [31:0] model_regs [4];
  int          err_count;
  int          test_err_base;
  int          tests_run;
  int          tests_failed;
  int          seed_ret;

  pms_top i_dut (
    .s_soc_clk       (s_soc_clk),
    .rst_n_i         (rst_n_i),
    .wr_en_i         (wr_en_i),
    .rd_en_i         (rd_en_i),
    .addr_i          (addr_i),
    .wdata_i         (wdata_i),
    .wstrb_i         (wstrb_i),
    .rdata_o         (rdata_o),
    .resp_valid_o    (resp_valid_o),
    .resp_err_o      (resp_err_o),
    .pwr_btn_n_i     (pwr_btn_n_i),
    .slp_s3_n_o      (slp_s3_n_o),
    .slp_s4_n_o      (slp_s4_n_o),
    .slp_s5_n_o      (slp_s5_n_o),
    .pwrgd_o         (pwrgd_o),
    .cpu_reset_n_o   (cpu_reset_n_o),
    .core_fetch_en_o (core_fetch_en_o),
    .core_boot_addr_o(core_boot_addr_o)
  );

  `include "tb_pms_tasks.svh"

  always #CLK_HALF_NS s_soc_clk = ~s_soc_clk;

  ////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////

  // 6 out of window, 7 unmapped offset, 8 upper byte set, else a register
  function automatic logic [39:0] random_address(input int kind);
    logic [31:0] r;
    logic [11:0] ofs;
    r = $urandom;
    case (kind)
      6: begin
        if (r[12]) begin
          random_address = {8'h00, `PMS_EXT_BASE + 32'h1000 + {18'h0, r[11:0], 2'b00}};
        end else begin
          random_address = {8'h00, `PMS_EXT_BASE - {18'h0, r[11:0], 2'b00} - 32'h4};
        end
      end
      7: begin
        ofs = {r[9:0], 2'b00};
        if (reg_index({8'h00, `PMS_EXT_BASE + {20'h0, ofs}}) >= 0) begin
          ofs = ofs + 12'h010;  // next free slot
        end
        random_address = {8'h00, `PMS_EXT_BASE + {20'h0, ofs}};
      end
      8: random_address = {r[7:0] | 8'h01, `PMS_EXT_BASE + {20'h0, reg_offset(r[9:8])}};
      default: random_address = reg_address(r[1:0]);
    endcase
  endfunction

  function automatic logic [7:0] random_strobe();
    logic [31:0] r;
    r = $urandom;
    case (r[10:8] % 3'd5)
      3'd0:    random_strobe = 8'h0F;
      3'd1:    random_strobe = 8'hF0;
      3'd2:    random_strobe = 8'hFF;
      3'd3:    random_strobe = 8'h00;
      default: random_strobe = r[7:0];  // partial halves
    endcase
  endfunction

  task automatic begin_test();
    test_err_base = err_count;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = err_count - test_err_base;
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errs);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    begin_test();
    for (int i = 0; i < 6; i++) begin
      if (probe(i) !== 1'b0) begin
        report_error($sformatf("%s not low after reset", signal_name(i)));
      end
    end
    if (resp_valid_o !== 1'b0) begin
      report_error("resp_valid_o not low after reset");
    end
    for (int i = 0; i < 4; i++) begin
      bus_access(1'b0, reg_address(2'(i)), 64'h0, 8'h00);
    end
    end_test("reset state");
  endtask

  task automatic test_random_traffic();
    int          kind;
    logic [39:0] addr;
    logic [63:0] data;
    logic [31:0] r;
    begin_test();
    for (int n = 0; n < RAND_OPS; n++) begin
      kind         = $urandom_range(9, 0);
      addr         = random_address(kind);
      r            = $urandom;
      data[63:32]  = r;
      r            = $urandom;
      data[31:0]   = r;
      bus_access($urandom_range(1, 0) == 1, addr, data, random_strobe());
      idle_cycles($urandom_range(2, 0));
    end
    // eoc flag with exit code 42
    bus_access(1'b1, reg_address(2'd2), 64'h0000_0000_8000_002A, 8'h0F);
    bus_access(1'b0, reg_address(2'd2), 64'h0, 8'h00);
    end_test("random register traffic");
  endtask

  // in S5 a glitch taken for a short press would start the power-up
  task automatic test_glitches_in_s5();
    logic [37:0] snap;
    begin_test();
    snap = output_snapshot();
    for (int i = 1; i < `PMS_BTN_MIN_CYC; i++) begin
      press_button(i);
      watch_outputs(snap, 12);
    end
    end_test("glitches in S5");
  endtask

  task automatic test_power_up();
    logic [31:0] r;
    logic [31:0] boot_val;
    int          waited;
    logic        ok;
    begin_test();
    r        = $urandom;
    boot_val = {r[31:2], 2'b00};
    bus_access(1'b1, reg_address(2'd0), {boot_val, 32'h0}, 8'hF0);
    bus_access(1'b1, reg_address(2'd1), 64'h0, 8'h0F);  // fetch off for now
    press_button($urandom_range(63, 4));
    wait_level(0, 1'b1, SYNC_STAGES + 6, waited, ok);
    if (ok && ((slp_s4_n_o !== 1'b0) || (slp_s3_n_o !== 1'b0) || (pwrgd_o !== 1'b0))) begin
      report_error("slp_s4_n_o, slp_s3_n_o or pwrgd_o high on entry to S4");
    end
    wait_level(1, 1'b1, 2 * `PMS_SEQ_STEP_CYC, waited, ok);
    if (ok && (waited != `PMS_SEQ_STEP_CYC)) begin
      report_error($sformatf("S4 lasted %0d cycles", waited));
    end
    if (ok && (slp_s3_n_o !== 1'b0)) begin
      report_error("slp_s3_n_o high on entry to S3");
    end
    wait_level(2, 1'b1, 2 * `PMS_SEQ_STEP_CYC, waited, ok);
    if (ok && (waited != `PMS_SEQ_STEP_CYC)) begin
      report_error($sformatf("S3 lasted %0d cycles", waited));
    end
    if (pwrgd_o !== 1'b1) begin
      report_error("pwrgd_o did not rise with entry to S0");
    end
    if (cpu_reset_n_o !== 1'b0) begin
      report_error("cpu_reset_n_o high together with pwrgd_o");
    end
    wait_level(4, 1'b1, 2 * `PMS_RST_REL_CYC, waited, ok);
    if (ok && (waited != `PMS_RST_REL_CYC)) begin
      report_error($sformatf("core reset released %0d cycles after pwrgd_o", waited));
    end
    bus_access(1'b1, reg_address(2'd1), 64'h1, 8'h0F);
    wait_level(5, 1'b1, 4, waited, ok);
    if (core_boot_addr_o !== boot_val) begin
      report_error($sformatf("core_boot_addr_o %h, expected %h", core_boot_addr_o, boot_val));
    end
    end_test("power-up");
  endtask

  task automatic test_ignored_presses();
    logic [37:0] snap;
    begin_test();
    snap = output_snapshot();
    for (int i = 0; i < 2; i++) begin
      press_button($urandom_range(`PMS_BTN_MIN_CYC - 1, 1));  // glitch
      watch_outputs(snap, 12);
    end
    for (int i = 0; i < 2; i++) begin
      press_button($urandom_range(`PMS_BTN_LONG_CYC - 1, `PMS_BTN_MIN_CYC));
      watch_outputs(snap, 12);
    end
    end_test("ignored presses");
  endtask

  task automatic test_forced_power_down();
    int waited;
    begin_test();
    press_button($urandom_range(100, `PMS_BTN_LONG_CYC));
    waited = 0;
    // release counts from the synchronised edge
    while ((output_snapshot() & 38'h3F_0000_0000) != 38'h0 && (waited < SYNC_STAGES + 3)) begin
      @(posedge s_soc_clk);
      #DRIVE_DLY;
      waited++;
    end
    if ((output_snapshot() & 38'h3F_0000_0000) != 38'h0) begin
      report_timeout("all power and core outputs low", SYNC_STAGES + 3);
    end
    for (int i = 0; i < 4; i++) begin
      bus_access(1'b0, reg_address(2'(i)), 64'h0, 8'h00);
    end
    end_test("forced power-down");
  endtask

  ////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    s_soc_clk     = 1'b0;
    rst_n_i       = 1'b0;
    wr_en_i       = 1'b0;
    rd_en_i       = 1'b0;
    addr_i        = 40'h0;
    wdata_i       = 64'h0;
    wstrb_i       = 8'h00;
    pwr_btn_n_i   = 1'b1;  // released
    err_count     = 0;
    test_err_base = 0;
    tests_run     = 0;
    tests_failed  = 0;
    seed_ret      = $urandom(32'he97);
    model_reset();

    repeat (RST_CYC) @(posedge s_soc_clk);
    #DRIVE_DLY;
    rst_n_i = 1'b1;

    test_reset_state();
    test_random_traffic();
    test_glitches_in_s5();
    test_power_up();
    test_ignored_presses();
    test_forced_power_down();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+common
+incdir+test
common/pms_pkg.sv
hw/soc_ctrl/soc_ctrl_regs.sv
hw/acpi/acpi_pwr_seq.sv
hw/core_release.sv
hw/pms_top.sv
test/tb_pms_top.sv

// File: Makefile
# Verilator build and run for the PMS testbench

VERILATOR ?= verilator
TOP       ?= tb_pms_top
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

SOURCES := $(wildcard common/*.sv common/*.svh hw/*.sv hw/*/*.sv test/*.sv test/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "run passed, log in $(LOG)"; \
	else \
	  echo "run failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
